/* common/shmem_pkg.sv */
// Shared memory subsystem types
package shmem_pkg;

    // command operation, one bit on the bus
    typedef enum logic {
        OP_READ  = 1'b0, // synchronous read, data one cycle later
        OP_WRITE = 1'b1  // write, response pulse only
    } cmd_op_e;

    // arbitration type
    typedef enum logic {
        ARB_PRIORITY    = 1'b0, // fixed priority
        ARB_ROUND_ROBIN = 1'b1  // rotating mask
    } arb_mode_e;

    // which end of the request vector wins
    typedef enum logic {
        LSB_LOW  = 1'b0, // index 0 first
        LSB_HIGH = 1'b1  // highest index first
    } lsb_prio_e;

    // client FSM states
    typedef enum logic {
        ST_IDLE = 1'b0, // free, accepts a command
        ST_REQ  = 1'b1  // command held, requesting the bus
    } client_state_e;

endpackage

/* verilog/arbiter/priority_encoder.sv */
// Priority encoder
module priority_encoder #(
    parameter int                   WIDTH    = 4,
    parameter shmem_pkg::lsb_prio_e LSB_PRIO = shmem_pkg::LSB_LOW
) (
    input  logic [WIDTH-1:0]         request_in,
    output logic                     valid,
    output logic [$clog2(WIDTH)-1:0] index,
    output logic [WIDTH-1:0]         onehot
);
    import shmem_pkg::*;

    localparam int IDX_W = $clog2(WIDTH);

    always_comb begin
        valid  = 1'b0;
        index  = '0;
        onehot = '0;
        if (LSB_PRIO == LSB_LOW) begin
            // scan down so the lowest set bit is the last one written
            for (int i = WIDTH - 1; i >= 0; i--) begin
                if (request_in[i]) begin
                    valid = 1'b1;
                    index = IDX_W'(i);
                end
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin // scan up, highest bit wins
                if (request_in[i]) begin
                    valid = 1'b1;
                    index = IDX_W'(i);
                end
            end
        end
        if (valid) begin
            onehot[index] = 1'b1; // one-hot of the winner
        end
    end

endmodule

/* verilog/arbiter/simple_arbiter.sv */
// Priority / round-robin arbiter
module simple_arbiter #(
    parameter int                   PORTS    = 4,
    parameter shmem_pkg::arb_mode_e ARB_MODE = shmem_pkg::ARB_ROUND_ROBIN,
    parameter shmem_pkg::lsb_prio_e LSB_PRIO = shmem_pkg::LSB_LOW
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [PORTS-1:0]         request,
    output logic [PORTS-1:0]         grant,
    output logic                     grant_valid,
    output logic [$clog2(PORTS)-1:0] grant_encoded
);
    import shmem_pkg::*;

    logic                     raw_valid;     // any request at all
    logic [$clog2(PORTS)-1:0] raw_index;
    logic [PORTS-1:0]         raw_onehot;
    logic [PORTS-1:0]         mask;          // ports still due this round
    logic [PORTS-1:0]         masked_request;
    logic                     masked_valid;
    logic [$clog2(PORTS)-1:0] masked_index;
    logic [PORTS-1:0]         masked_onehot;
    logic                     use_masked;

    assign masked_request = request & mask;

    priority_encoder #(.WIDTH(PORTS), .LSB_PRIO(LSB_PRIO)) u_enc_raw (
        .request_in (request),
        .valid      (raw_valid),
        .index      (raw_index),
        .onehot     (raw_onehot)
    );

    priority_encoder #(.WIDTH(PORTS), .LSB_PRIO(LSB_PRIO)) u_enc_masked (
        .request_in (masked_request),
        .valid      (masked_valid),
        .index      (masked_index),
        .onehot     (masked_onehot)
    );

    // rotate after every valid grant, the RAM always takes the access
    always_ff @(posedge clk) begin
        if (rst) begin
            mask <= '0; // first grant falls to the raw encoder
        end else if (grant_valid) begin
            if (LSB_PRIO == LSB_LOW) begin
                mask <= {PORTS{1'b1}} << (grant_encoded + 1); // indices above g
            end else begin
                mask <= {PORTS{1'b1}} >> (PORTS - grant_encoded); // indices below g
            end
        end
    end

    // masked winner first, wrap to the raw one when nothing is left
    assign use_masked    = (ARB_MODE == ARB_ROUND_ROBIN) && masked_valid;
    assign grant_valid   = raw_valid; // masked valid implies raw valid
    assign grant         = use_masked ? masked_onehot : raw_onehot;
    assign grant_encoded = use_masked ? masked_index  : raw_index;

endmodule

/* verilog/mem_client.sv */
// Memory client
module mem_client #(
    parameter int ADDR_W = 6,
    parameter int DATA_W = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  shmem_pkg::cmd_op_e  cmd_op,
    input  logic [ADDR_W-1:0]   cmd_addr,
    input  logic [DATA_W-1:0]   cmd_wdata,
    input  logic                grant,
    output logic                request,
    output logic                busy,
    output shmem_pkg::cmd_op_e  bus_op,
    output logic [ADDR_W-1:0]   bus_addr,
    output logic [DATA_W-1:0]   bus_wdata
);
    import shmem_pkg::*;

    client_state_e state;
    logic          capture; // strobe seen while free

    assign capture = (state == ST_IDLE) && cmd_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        state <= ST_REQ; // hold command, ask for the bus
                    end
                end
                ST_REQ: begin
                    if (grant) begin
                        state <= ST_IDLE; // access goes out this cycle
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // held command, stays on the bus until granted
    always_ff @(posedge clk) begin
        if (capture) begin
            bus_op    <= cmd_op;
            bus_addr  <= cmd_addr;
            bus_wdata <= cmd_wdata;
        end
    end

    // strobes in ST_REQ are dropped, busy tells the sender to wait
    assign request = (state == ST_REQ);
    assign busy    = (state == ST_REQ);

endmodule

/* verilog/mem_port.sv */
// Shared memory port
module mem_port #(
    parameter int PORTS  = 4,
    parameter int ADDR_W = 6,
    parameter int DATA_W = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [PORTS-1:0]               grant,
    input  logic                           grant_valid,
    input  logic [$clog2(PORTS)-1:0]       grant_encoded,
    input  shmem_pkg::cmd_op_e [PORTS-1:0] bus_op,
    input  logic [PORTS-1:0][ADDR_W-1:0]   bus_addr,
    input  logic [PORTS-1:0][DATA_W-1:0]   bus_wdata,
    output logic [PORTS-1:0]               rsp_valid,
    output logic [DATA_W-1:0]              rsp_data
);
    import shmem_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    cmd_op_e           sel_op;    // granted client's operation
    logic [ADDR_W-1:0] sel_addr;
    logic [DATA_W-1:0] sel_wdata;
    logic [DATA_W-1:0] ram [DEPTH]; // single-port array

    // bus mux by the encoded grant
    assign sel_op    = bus_op[grant_encoded];
    assign sel_addr  = bus_addr[grant_encoded];
    assign sel_wdata = bus_wdata[grant_encoded];

    // one access per cycle, read is synchronous
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            if (sel_op == OP_WRITE) begin
                ram[sel_addr] <= sel_wdata;
            end else begin
                rsp_data <= ram[sel_addr]; // valid only for read responses
            end
        end
    end

    // response pulse goes back to the port that was granted
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= '0;
        end else if (grant_valid) begin
            rsp_valid <= grant; // one-hot
        end else begin
            rsp_valid <= '0;
        end
    end

endmodule

/* verilog/shmem_top.sv */
// Shared memory subsystem top
module shmem_top #(
    parameter int                   PORTS    = 4,
    parameter int                   ADDR_W   = 6,
    parameter int                   DATA_W   = 16,
    parameter shmem_pkg::arb_mode_e ARB_MODE = shmem_pkg::ARB_ROUND_ROBIN,
    parameter shmem_pkg::lsb_prio_e LSB_PRIO = shmem_pkg::LSB_LOW
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [PORTS-1:0]               cmd_valid,
    input  shmem_pkg::cmd_op_e [PORTS-1:0] cmd_op,
    input  logic [PORTS-1:0][ADDR_W-1:0]   cmd_addr,
    input  logic [PORTS-1:0][DATA_W-1:0]   cmd_wdata,
    output logic [PORTS-1:0]               busy,
    output logic [PORTS-1:0]               rsp_valid,
    output logic [DATA_W-1:0]              rsp_data
);
    import shmem_pkg::*;

    logic [PORTS-1:0]             request;       // one per client
    logic [PORTS-1:0]             grant;
    logic                         grant_valid;
    logic [$clog2(PORTS)-1:0]     grant_encoded;
    cmd_op_e [PORTS-1:0]          bus_op;        // held commands
    logic [PORTS-1:0][ADDR_W-1:0] bus_addr;
    logic [PORTS-1:0][DATA_W-1:0] bus_wdata;

    for (genvar i = 0; i < PORTS; i++) begin : g_client
        mem_client #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_client (
            .clk       (clk),
            .rst       (rst),
            .cmd_valid (cmd_valid[i]),
            .cmd_op    (cmd_op[i]),
            .cmd_addr  (cmd_addr[i]),
            .cmd_wdata (cmd_wdata[i]),
            .grant     (grant[i]),
            .request   (request[i]),
            .busy      (busy[i]),
            .bus_op    (bus_op[i]),
            .bus_addr  (bus_addr[i]),
            .bus_wdata (bus_wdata[i])
        );
    end

    simple_arbiter #(.PORTS(PORTS), .ARB_MODE(ARB_MODE), .LSB_PRIO(LSB_PRIO)) u_arb (
        .clk           (clk),
        .rst           (rst),
        .request       (request),
        .grant         (grant),
        .grant_valid   (grant_valid),
        .grant_encoded (grant_encoded)
    );

    mem_port #(.PORTS(PORTS), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mem (
        .clk           (clk),
        .rst           (rst),
        .grant         (grant),
        .grant_valid   (grant_valid),
        .grant_encoded (grant_encoded),
        .bus_op        (bus_op),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data)
    );

endmodule

/* tb/clk_gen.sv */
// Testbench clock source
module clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0; // first rising edge at half a period
    end

    always #(PERIOD / 2) clk = ~clk; // even duty cycle

endmodule

/* tb/shmem_assert.sv */
// Arbiter grant checks
module shmem_assert #(
    parameter int PORTS = 4
) (
    input logic             clk,
    input logic             rst,
    input logic [PORTS-1:0] request,
    input logic [PORTS-1:0] grant,
    input logic             grant_valid
);

    // at most one winner per cycle
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("grant is not one-hot or zero");

    a_valid_any: assert property (@(posedge clk) disable iff (rst) grant_valid == (|request))
        else $error("grant_valid does not follow the request vector");

    a_grant_requested: assert property (@(posedge clk) disable iff (rst)
        (grant & ~request) == '0)
        else $error("grant given to a port that is not requesting");

endmodule

bind simple_arbiter shmem_assert #(.PORTS(PORTS)) u_assert (
    .clk         (clk),
    .rst         (rst),
    .request     (request),
    .grant       (grant),
    .grant_valid (grant_valid)
);

/* tb/shmem_tb.sv */
// Shared memory testbench
module shmem_tb;
    import shmem_pkg::*;

    localparam int          PORTS     = 4;
    localparam int          ADDR_W    = 6;
    localparam int          DATA_W    = 16;
    localparam int          MAX_LINES = 32;
    localparam int          COLS      = 6;      // group port op addr wdata rdata
    localparam logic [15:0] END_GROUP = 16'h00ff;

    logic                         clk;
    logic                         rst;
    logic [PORTS-1:0]             cmd_valid;
    cmd_op_e [PORTS-1:0]          cmd_op;
    logic [PORTS-1:0][ADDR_W-1:0] cmd_addr;
    logic [PORTS-1:0][DATA_W-1:0] cmd_wdata;
    logic [PORTS-1:0]             busy;
    logic [PORTS-1:0]             rsp_valid;
    logic [DATA_W-1:0]            rsp_data;

    logic [15:0]       golden [MAX_LINES*COLS]; // flat table, six words per line
    logic [DATA_W-1:0] model [1 << ADDR_W];     // reference memory
    int                last_grant;              // -1 until the first grant
    int                seed        = 32'h704b;
    int                cycle_count = 0;
    int                cycle_limit = 1000;     // replaced once the file is read

    clk_gen #(.PERIOD(100)) u_clk (.clk(clk));

    shmem_top uut (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, responses never completed", cycle_limit);
            $display("test failed");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: expected %0h, got %0h", $time, what, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // round robin: lowest pending above the last grant, else wrap to lowest
    function automatic int next_grant(input logic [PORTS-1:0] pending, input int last);
        int pick;
        pick = -1;
        for (int p = PORTS - 1; p > last; p--) begin
            if (pending[p]) pick = p;
        end
        if (pick < 0) begin
            for (int p = PORTS - 1; p >= 0; p--) begin
                if (pending[p]) pick = p;
            end
        end
        return pick;
    endfunction

    task automatic run_group(input int first, input int count);
        logic [PORTS-1:0]             members;
        logic [PORTS-1:0]             pending;
        logic [PORTS-1:0]             exp_rsp;
        logic [PORTS-1:0]             exp_busy;
        cmd_op_e [PORTS-1:0]          op_v;
        logic [PORTS-1:0][ADDR_W-1:0] addr_v;
        logic [PORTS-1:0][DATA_W-1:0] wdata_v;
        logic [DATA_W-1:0]            gold_rdata [PORTS];
        logic [DATA_W-1:0]            model_rdata [PORTS];
        int                           resp_cycle [PORTS]; // negedges after the drive edge
        int                           row;
        int                           p;
        members = '0;
        op_v    = cmd_op;
        addr_v  = cmd_addr;
        wdata_v = cmd_wdata;
        for (int k = 0; k < count; k++) begin
            row              = (first + k) * COLS;
            p                = int'(golden[row + 1]);
            members[p]       = 1'b1;
            op_v[p]          = cmd_op_e'(golden[row + 2][0]);
            addr_v[p]        = golden[row + 3][ADDR_W-1:0];
            wdata_v[p]       = golden[row + 4];
            gold_rdata[p]    = golden[row + 5];
        end
        pending = members;
        for (int k = 0; k < count; k++) begin
            p             = next_grant(pending, last_grant);
            pending[p]    = 1'b0;
            last_grant    = p;
            resp_cycle[p] = 2 + k; // capture edge, then one access per edge
            if (op_v[p] == OP_WRITE) begin
                model[addr_v[p]] = wdata_v[p]; // writes land in grant order
            end else begin
                model_rdata[p] = model[addr_v[p]];
            end
        end
        @(posedge clk);
        cmd_valid <= members;
        cmd_op    <= op_v;
        cmd_addr  <= addr_v;
        cmd_wdata <= wdata_v;
        for (int c = 0; c <= count + 1; c++) begin
            @(negedge clk); // outputs settled mid-cycle
            for (int q = 0; q < PORTS; q++) begin
                exp_rsp[q]  = members[q] && (resp_cycle[q] == c);
                exp_busy[q] = members[q] && (c >= 1) && (c < resp_cycle[q]);
            end
            check_value(32'(exp_rsp), 32'(rsp_valid), "rsp_valid");
            check_value(32'(exp_busy), 32'(busy), "busy");
            for (int q = 0; q < PORTS; q++) begin
                if (exp_rsp[q] && op_v[q] == OP_READ) begin
                    check_value(32'(gold_rdata[q]), 32'(rsp_data),
                                $sformatf("port %0d read data", q));
                    check_value(32'(model_rdata[q]), 32'(rsp_data),
                                $sformatf("port %0d model data", q));
                end
            end
            if (c == 0) begin
                @(posedge clk);
                cmd_valid <= '0; // one-cycle strobe
            end
        end
    endtask

    initial begin
        int row;
        int first;
        int count;
        int num_groups;
        int rnd;
        logic [15:0] prev_group;
        rst       = 1'b1;
        cmd_valid = '0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        for (int q = 0; q < PORTS; q++) begin
            cmd_op[q] = OP_READ;
        end
        $readmemh("tb/shmem_golden.txt", golden);
        num_groups = 0;
        prev_group = 16'hffff;
        row        = 0;
        while (row < MAX_LINES && golden[row*COLS] !== END_GROUP) begin
            if (golden[row*COLS] !== prev_group) num_groups++;
            prev_group = golden[row*COLS];
            row++;
        end
        cycle_limit = 16 + num_groups * (PORTS * 2 + 3 + 4);
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(32'h0, 32'(busy), "busy after reset");
        check_value(32'h0, 32'(rsp_valid), "rsp_valid after reset");
        last_grant = -1; // mask is zero out of reset
        row        = 0;
        while (row < MAX_LINES && golden[row*COLS] !== END_GROUP) begin
            first = row;
            count = 0;
            while (row < MAX_LINES && golden[row*COLS] === golden[first*COLS]) begin
                row++;
                count++;
            end
            run_group(first, count);
            rnd = $random(seed);
            repeat (rnd & 3) @(posedge clk); // idle gap of 0 to 3 cycles
        end
        $display("test passed");
        $finish;
    end

endmodule

/* tb/shmem_golden.txt */
// columns are group, port, op, addr, wdata and expected rdata in hex
// op 1 writes and op 0 reads, rdata is compared on reads only
// group ff marks the end of the list
00 0 1 05 1234 0000
01 0 0 05 0000 1234
02 0 1 10 1111 0000
02 1 1 11 2222 0000
02 2 1 12 3333 0000
02 3 1 13 4444 0000
03 1 1 20 aaaa 0000
03 3 1 20 bbbb 0000
04 0 1 21 c0de 0000
04 1 1 22 5a5a 0000
04 2 1 21 d00d 0000
04 3 1 23 0f0f 0000
05 0 0 20 0000 bbbb
05 1 0 21 0000 d00d
05 2 0 22 0000 5a5a
05 3 0 10 0000 1111
06 2 0 11 0000 2222
06 0 0 23 0000 0f0f
07 0 0 12 0000 3333
07 1 0 13 0000 4444
07 2 0 05 0000 1234
07 3 0 23 0000 0f0f
ff 0 0 00 0000 0000

/* shmem.f */
common/shmem_pkg.sv
verilog/arbiter/priority_encoder.sv
verilog/arbiter/simple_arbiter.sv
verilog/mem_client.sv
verilog/mem_port.sv
verilog/shmem_top.sv
tb/clk_gen.sv
tb/shmem_assert.sv
tb/shmem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= shmem_tb
FILELIST  ?= shmem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
